// ==== src/elevator_config.svh ====
/*
 * Sizing macros for the elevator request controller.
 * Include this header in any file that needs floor or stack widths.
 */

`ifndef ELEVATOR_CONFIG_SVH
`define ELEVATOR_CONFIG_SVH

////////////////////////////////////////////////////////////
// Building size
////////////////////////////////////////////////////////////

// Floors are numbered 0 (lowest) to NUM_FLOORS-1
`define NUM_FLOORS 11
`define FLOOR_W 4

////////////////////////////////////////////////////////////
// Request stack
////////////////////////////////////////////////////////////

// One slot per floor is enough, pending floors are unique
`define STACK_DEPTH 11
`define PTR_W 4

`endif

// ==== src/elevator_pkg.sv ====
/*
 * Shared types for the elevator request controller.
 * Modules refer to these by scoped names, elevator_pkg::floor_t and so on.
 */

`include "elevator_config.svh"

package elevator_pkg;

    // Floor number, 0 is the lowest floor
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, used for buttons and lights
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    // Status reported by the car-motion controller
    typedef enum logic [1:0] {
        CAR_STOPPED     = 2'd0,
        CAR_MOVING_UP   = 2'd1,
        CAR_MOVING_DOWN = 2'd2,
        CAR_FAULT       = 2'd3
    } car_state_t;

    // Request controller state
    typedef enum logic [1:0] {
        CTRL_OFF       = 2'd0,
        CTRL_READY     = 2'd1,
        CTRL_EMERGENCY = 2'd2
    } ctrl_state_t;

endpackage

// ==== src/request_scanner.sv ====
/*
 * Button scanner. Accepts at most one press per cycle, panel floors first,
 * then hall floors, lights the accepted button and requests a stack push
 * when the floor was not already pending.
 */

`include "elevator_config.svh"

module request_scanner (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      accept_enable,
    input  logic                      serve,
    input  logic                      clear_requests,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::floor_mask_t call_lights,
    output logic                      push,
    output elevator_pkg::floor_t      push_floor
);

    logic                 found;
    logic                 sel_panel;
    elevator_pkg::floor_t sel_floor;

    ////////////////////////////////////////////////////////////
    // Priority scan
    ////////////////////////////////////////////////////////////

    always_comb begin
        found     = 1'b0;
        sel_panel = 1'b0;
        sel_floor = '0;
        // Panel buttons win over hall buttons, lower floors first
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (!found && accept_enable && panel_buttons[i] && !panel_lights[i] &&
                    (i != int'(current_floor))) begin
                found     = 1'b1;
                sel_panel = 1'b1;
                sel_floor = elevator_pkg::floor_t'(i);
            end
        end
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (!found && accept_enable && floor_call_buttons[i] && !call_lights[i] &&
                    (i != int'(current_floor))) begin
                found     = 1'b1;
                sel_panel = 1'b0;
                sel_floor = elevator_pkg::floor_t'(i);
            end
        end
    end

    // A floor goes on the stack only once, whichever button asked first
    assign push       = found && !panel_lights[sel_floor] && !call_lights[sel_floor];
    assign push_floor = sel_floor;

    ////////////////////////////////////////////////////////////
    // Button lights
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else if (clear_requests) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            // Served floor and accepted floor never coincide
            if (serve) begin
                panel_lights[current_floor] <= 1'b0;
                call_lights[current_floor]  <= 1'b0;
            end
            if (found) begin
                if (sel_panel) begin
                    panel_lights[sel_floor] <= 1'b1;
                end else begin
                    call_lights[sel_floor] <= 1'b1;
                end
            end
        end
    end

    // Every pending floor keeps a lit button until it is served
    a_serve_lit: assert property (@(posedge clock) disable iff (!reset_n)
        serve |-> (panel_lights[current_floor] || call_lights[current_floor]))
        else $error("served floor has no lit button");

endmodule

// ==== src/request_stack.sv ====
/*
 * LIFO of pending target floors. The newest entry is shown on top_floor.
 * A push and a pop in the same cycle replace the top entry, and
 * clear_requests empties the stack.
 */

`include "elevator_config.svh"

module request_stack (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 push,
    input  elevator_pkg::floor_t push_floor,
    input  logic                 pop,
    input  logic                 clear_requests,
    output elevator_pkg::floor_t top_floor,
    output logic                 stack_empty
);

    elevator_pkg::floor_t   stack_mem [`STACK_DEPTH];
    logic [`PTR_W-1:0]      ptr;
    logic [`PTR_W-1:0]      top_idx;
    logic [`PTR_W-1:0]      wr_idx;
    logic                   do_push;
    logic                   do_pop;

    ////////////////////////////////////////////////////////////
    // Pointer and top of stack
    ////////////////////////////////////////////////////////////

    // ptr counts entries, so the top sits one below it
    assign stack_empty = (ptr == '0);
    assign top_idx     = ptr - 1'b1;
    assign top_floor   = stack_empty ? '0 : stack_mem[top_idx];

    assign do_push = push && !clear_requests;
    assign do_pop  = pop && !clear_requests && !stack_empty;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (clear_requests) begin
            ptr <= '0;
        end else if (do_push && !do_pop) begin
            ptr <= ptr + 1'b1;
        end else if (do_pop && !do_push) begin
            ptr <= ptr - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////////////////////////

    // Push with pop overwrites the served top entry
    assign wr_idx = do_pop ? top_idx : ptr;

    always_ff @(posedge clock) begin
        if (do_push) begin
            stack_mem[wr_idx] <= push_floor;
        end
    end

    // Serve comes from the dispatch FSM and must only see a filled stack
    a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> !stack_empty)
        else $error("pop requested on empty stack");

    // Unique pending floors keep the stack within its slots
    a_ptr_range: assert property (@(posedge clock) disable iff (!reset_n)
        ptr <= `STACK_DEPTH)
        else $error("stack pointer beyond depth");

endmodule

// ==== src/dispatch_fsm.sv ====
/*
 * Controller state machine. Tracks power and emergency, sends the top
 * stack floor to the car, pulses serve on arrival and gates the door
 * buttons while the car is stopped.
 */

`include "elevator_config.svh"

module dispatch_fsm (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     power_switch,
    input  logic                     emergency_btn,
    input  elevator_pkg::car_state_t car_state,
    input  elevator_pkg::floor_t     current_floor,
    input  elevator_pkg::floor_t     top_floor,
    input  logic                     stack_empty,
    input  logic                     door_open_btn,
    input  logic                     door_close_btn,
    output logic                     accept_enable,
    output logic                     clear_requests,
    output logic                     serve,
    output logic                     activate_elevator,
    output elevator_pkg::floor_t     floor_selector,
    output logic                     direction_up,
    output logic                     emergency_active,
    output logic                     door_open_allowed,
    output logic                     door_close_allowed
);

    elevator_pkg::ctrl_state_t state;
    elevator_pkg::ctrl_state_t next_state;
    logic                      car_stopped;
    logic                      dispatch_ok;

    ////////////////////////////////////////////////////////////
    // State register and transitions
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= elevator_pkg::CTRL_OFF;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (!power_switch) begin
            next_state = elevator_pkg::CTRL_OFF;
        end else if (emergency_btn) begin
            next_state = elevator_pkg::CTRL_EMERGENCY;
        end else begin
            case (state)
                elevator_pkg::CTRL_OFF:       next_state = elevator_pkg::CTRL_READY;
                // Leave emergency only once the car has come to rest
                elevator_pkg::CTRL_EMERGENCY: begin
                    if (car_stopped) begin
                        next_state = elevator_pkg::CTRL_READY;
                    end
                end
                default:                      next_state = elevator_pkg::CTRL_READY;
            endcase
        end
    end

    assign car_stopped    = (car_state == elevator_pkg::CAR_STOPPED);
    assign clear_requests = (next_state != elevator_pkg::CTRL_READY);
    assign accept_enable  = (state == elevator_pkg::CTRL_READY) && !clear_requests;

    ////////////////////////////////////////////////////////////
    // Dispatch
    ////////////////////////////////////////////////////////////

    assign dispatch_ok = (state == elevator_pkg::CTRL_READY) && car_stopped && !stack_empty;

    // Either send the car off or serve the floor it already stands at
    assign activate_elevator = dispatch_ok && (top_floor != current_floor);
    assign serve             = dispatch_ok && (top_floor == current_floor);

    assign floor_selector = activate_elevator ? top_floor : current_floor;
    assign direction_up   = activate_elevator ? (top_floor > current_floor) : 1'b1;

    assign emergency_active = (state == elevator_pkg::CTRL_EMERGENCY);

    // Doors respond only with power on and the car at rest
    assign door_open_allowed  = (state != elevator_pkg::CTRL_OFF) && car_stopped && door_open_btn;
    assign door_close_allowed = (state != elevator_pkg::CTRL_OFF) && car_stopped &&
                                door_close_btn;

    // The served floor never shows up again on top of the stack
    a_serve_leaves_top: assert property (@(posedge clock) disable iff (!reset_n)
        serve |=> (stack_empty || (top_floor != $past(top_floor))))
        else $error("served floor still on top of the stack");

endmodule

// ==== src/elevator_request_ctrl.sv ====
/*
 * Top level of the elevator request controller. Connects the button
 * scanner, the request stack and the dispatch FSM. The car-motion
 * controller sits outside and drives current_floor and car_state.
 */

`include "elevator_config.svh"

module elevator_request_ctrl (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  elevator_pkg::car_state_t  car_state,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::floor_mask_t call_lights,
    output logic                      activate_elevator,
    output elevator_pkg::floor_t      floor_selector,
    output logic                      direction_up,
    output logic                      emergency_active,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    // Scanner to stack
    logic                 push;
    elevator_pkg::floor_t push_floor;

    // Stack to FSM
    elevator_pkg::floor_t top_floor;
    logic                 stack_empty;

    // FSM to scanner and stack
    logic                 accept_enable;
    logic                 clear_requests;
    logic                 serve;

    request_scanner u_scanner (
        .clock              (clock),
        .reset_n            (reset_n),
        .panel_buttons      (panel_buttons),
        .floor_call_buttons (floor_call_buttons),
        .current_floor      (current_floor),
        .accept_enable      (accept_enable),
        .serve              (serve),
        .clear_requests     (clear_requests),
        .panel_lights       (panel_lights),
        .call_lights        (call_lights),
        .push               (push),
        .push_floor         (push_floor)
    );

    // Serve pops the floor the car has just reached
    request_stack u_stack (
        .clock          (clock),
        .reset_n        (reset_n),
        .push           (push),
        .push_floor     (push_floor),
        .pop            (serve),
        .clear_requests (clear_requests),
        .top_floor      (top_floor),
        .stack_empty    (stack_empty)
    );

    dispatch_fsm u_fsm (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .car_state          (car_state),
        .current_floor      (current_floor),
        .top_floor          (top_floor),
        .stack_empty        (stack_empty),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .accept_enable      (accept_enable),
        .clear_requests     (clear_requests),
        .serve              (serve),
        .activate_elevator  (activate_elevator),
        .floor_selector     (floor_selector),
        .direction_up       (direction_up),
        .emergency_active   (emergency_active),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== tests/tb_elevator_request_ctrl.sv ====
/*
 * Testbench for the elevator request controller. Models the car, drives
 * button presses and checks every output each cycle against a reference
 * model of the lights, the request stack and the controller state.
 */

`include "elevator_config.svh"

module tb_elevator_request_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES = 1000;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t floor_call_buttons;
    elevator_pkg::floor_mask_t panel_buttons;
    logic                      door_open_btn;
    logic                      door_close_btn;
    logic                      emergency_btn;
    logic                      power_switch;
    elevator_pkg::floor_t      current_floor;
    elevator_pkg::car_state_t  car_state;
    elevator_pkg::floor_mask_t panel_lights;
    elevator_pkg::floor_mask_t call_lights;
    logic                      activate_elevator;
    elevator_pkg::floor_t      floor_selector;
    logic                      direction_up;
    logic                      emergency_active;
    logic                      door_open_allowed;
    logic                      door_close_allowed;

    // Car model
    logic                 car_busy;
    logic                 car_hold;
    elevator_pkg::floor_t car_target;
    int                   step_count;

    // Reference model
    elevator_pkg::ctrl_state_t ref_state;
    elevator_pkg::floor_mask_t ref_panel;
    elevator_pkg::floor_mask_t ref_call;
    elevator_pkg::floor_t      ref_stack [`STACK_DEPTH];
    int                        ref_ptr;

    int          cycle_count;
    logic [31:0] rng_state;

    elevator_request_ctrl UUT (.*);

    ////////////////////////////////////////////////////////////
    // Clock, timeout and failure
    ////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > CYCLE_LIMIT) begin
                fail_run("Timeout: the tests did not finish within the cycle limit");
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    ////////////////////////////////////////////////////////////
    // Car model
    ////////////////////////////////////////////////////////////

    // Pick up a dispatch while the car is at rest
    initial begin
        forever begin
            @(negedge clock);
            if (reset_n && !car_busy && !car_hold && activate_elevator) begin
                car_busy   = 1'b1;
                car_target = floor_selector;
                step_count = 0;
            end
        end
    end

    // One floor per 3 cycles toward the target
    initial begin
        forever begin
            next_cycle();
            if (car_hold) begin
                car_state = elevator_pkg::CAR_FAULT;
            end else if (car_busy) begin
                if (current_floor == car_target) begin
                    car_busy  = 1'b0;
                    car_state = elevator_pkg::CAR_STOPPED;
                end else begin
                    car_state = (car_target > current_floor) ? elevator_pkg::CAR_MOVING_UP
                                                             : elevator_pkg::CAR_MOVING_DOWN;
                    step_count++;
                    if (step_count == 3) begin
                        step_count = 0;
                        if (car_target > current_floor) begin
                            current_floor = current_floor + 1'b1;
                        end else begin
                            current_floor = current_floor - 1'b1;
                        end
                    end
                end
            end else begin
                car_state = elevator_pkg::CAR_STOPPED;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checker
    ////////////////////////////////////////////////////////////

    // Packed as act, selector, direction, emergency, door open, door close
    function automatic logic [8:0] compute_expected();
        logic                 stopped;
        logic                 ok;
        logic                 act;
        elevator_pkg::floor_t top;
        elevator_pkg::floor_t sel;
        logic                 dir;
        logic                 powered;
        stopped = (car_state == elevator_pkg::CAR_STOPPED);
        top     = (ref_ptr > 0) ? ref_stack[ref_ptr-1] : '0;
        ok      = (ref_state == elevator_pkg::CTRL_READY) && stopped && (ref_ptr > 0);
        act     = ok && (top != current_floor);
        sel     = act ? top : current_floor;
        dir     = act ? (top > current_floor) : 1'b1;
        powered = (ref_state != elevator_pkg::CTRL_OFF);
        return {act, sel, dir, ref_state == elevator_pkg::CTRL_EMERGENCY,
                powered && stopped && door_open_btn, powered && stopped && door_close_btn};
    endfunction

    task automatic update_model();
        elevator_pkg::ctrl_state_t ns;
        elevator_pkg::floor_t      top;
        elevator_pkg::floor_t      f;
        logic                      clear;
        logic                      accept;
        logic                      serve;
        logic                      found;
        logic                      is_panel;
        logic                      push;
        if (!power_switch) begin
            ns = elevator_pkg::CTRL_OFF;
        end else if (emergency_btn) begin
            ns = elevator_pkg::CTRL_EMERGENCY;
        end else if (ref_state == elevator_pkg::CTRL_EMERGENCY &&
                     car_state != elevator_pkg::CAR_STOPPED) begin
            ns = elevator_pkg::CTRL_EMERGENCY;
        end else begin
            ns = elevator_pkg::CTRL_READY;
        end
        clear  = (ns != elevator_pkg::CTRL_READY);
        accept = (ref_state == elevator_pkg::CTRL_READY) && !clear;
        top    = (ref_ptr > 0) ? ref_stack[ref_ptr-1] : '0;
        serve  = (ref_state == elevator_pkg::CTRL_READY) && (ref_ptr > 0) &&
                 (car_state == elevator_pkg::CAR_STOPPED) && (top == current_floor);
        found    = 1'b0;
        is_panel = 1'b0;
        f        = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (!found && accept && panel_buttons[i] && !ref_panel[i] &&
                    (elevator_pkg::floor_t'(i) != current_floor)) begin
                found    = 1'b1;
                is_panel = 1'b1;
                f        = elevator_pkg::floor_t'(i);
            end
        end
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (!found && accept && floor_call_buttons[i] && !ref_call[i] &&
                    (elevator_pkg::floor_t'(i) != current_floor)) begin
                found = 1'b1;
                f     = elevator_pkg::floor_t'(i);
            end
        end
        push = found && !ref_panel[f] && !ref_call[f];
        if (clear) begin
            ref_panel = '0;
            ref_call  = '0;
            ref_ptr   = 0;
        end else begin
            if (serve) begin
                ref_panel[current_floor] = 1'b0;
                ref_call[current_floor]  = 1'b0;
            end
            if (found && is_panel) ref_panel[f] = 1'b1;
            if (found && !is_panel) ref_call[f] = 1'b1;
            if (push && serve) begin
                ref_stack[ref_ptr-1] = f;
            end else if (push) begin
                ref_stack[ref_ptr] = f;
                ref_ptr++;
            end else if (serve) begin
                ref_ptr--;
            end
        end
        ref_state = ns;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_run("Output mismatch against the reference model");
        end
    endtask

    // Mid-cycle compare, then step the model to the next edge
    initial begin
        logic [8:0] exp;
        forever begin
            @(negedge clock);
            if (!reset_n) begin
                ref_state = elevator_pkg::CTRL_OFF;
                ref_panel = '0;
                ref_call  = '0;
                ref_ptr   = 0;
            end else begin
                exp = compute_expected();
                check_value("panel_lights", 16'(panel_lights), 16'(ref_panel));
                check_value("call_lights", 16'(call_lights), 16'(ref_call));
                check_value("activate_elevator", 16'(activate_elevator), 16'(exp[8]));
                check_value("floor_selector", 16'(floor_selector), 16'(exp[7:4]));
                check_value("direction_up", 16'(direction_up), 16'(exp[3]));
                check_value("emergency_active", 16'(emergency_active), 16'(exp[2]));
                check_value("door_open_allowed", 16'(door_open_allowed), 16'(exp[1]));
                check_value("door_close_allowed", 16'(door_close_allowed), 16'(exp[0]));
                update_model();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic press(input logic panel, input int fl);
        if (panel) panel_buttons[fl] = 1'b1;
        else floor_call_buttons[fl] = 1'b1;
        next_cycle();
        panel_buttons      = '0;
        floor_call_buttons = '0;
    endtask

    task automatic wait_idle();
        while (car_busy || ref_ptr != 0 || car_state != elevator_pkg::CAR_STOPPED) begin
            next_cycle();
        end
        next_cycle();
    endtask

    initial begin
        reset_n            = 1'b0;
        panel_buttons      = '0;
        floor_call_buttons = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        car_state          = elevator_pkg::CAR_STOPPED;
        car_busy           = 1'b0;
        car_hold           = 1'b0;
        car_target         = '0;
        step_count         = 0;
        rng_state          = 32'hb513afb5;
        repeat (2) next_cycle();
        reset_n = 1'b1;
        repeat (2) next_cycle();

        // Reset state and first dispatch upward
        assert (panel_lights == '0 && call_lights == '0 && !activate_elevator)
            else fail_run("Lights or dispatch active after reset");
        press(1'b1, 5);
        assert (panel_lights[5] && activate_elevator && direction_up)
            else fail_run("Panel press did not light and dispatch upward");
        wait_idle();

        // Newest floor first, current and pending floors add no entry
        car_hold = 1'b1;
        next_cycle();
        press(1'b1, 2);
        press(1'b0, 8);
        press(1'b1, 5);
        press(1'b0, 2);
        assert (panel_lights == 11'h004 && call_lights == 11'h104)
            else fail_run("Lights wrong after presses for the current and a pending floor");
        car_hold = 1'b0;
        while (!activate_elevator) next_cycle();
        assert (floor_selector == 4'd8) else fail_run("Newest floor was not served first");

        // Arrival clears the floor and dispatches the next entry
        while (!(activate_elevator && floor_selector == 4'd2)) next_cycle();
        assert (!panel_lights[8] && !call_lights[8])
            else fail_run("Lights of the served floor did not clear");
        wait_idle();

        // Emergency during a run, then power off
        press(1'b1, 0);
        press(1'b0, 9);
        while (car_state == elevator_pkg::CAR_STOPPED) next_cycle();
        emergency_btn = 1'b1;
        repeat (3) next_cycle();
        assert (emergency_active && panel_lights == '0 && call_lights == '0)
            else fail_run("Emergency did not clear requests");
        emergency_btn = 1'b0;
        while (car_state != elevator_pkg::CAR_STOPPED) next_cycle();
        repeat (2) next_cycle();
        assert (!emergency_active) else fail_run("Controller did not leave emergency");
        press(1'b1, 6);
        power_switch  = 1'b0;
        door_open_btn = 1'b1;
        repeat (3) next_cycle();
        assert (!door_open_allowed && panel_lights == '0)
            else fail_run("Power off did not clear requests or block doors");
        door_open_btn = 1'b0;
        power_switch  = 1'b1;
        wait_idle();

        // Door permits with the car not at rest
        car_hold       = 1'b1;
        door_close_btn = 1'b1;
        repeat (2) next_cycle();
        assert (!door_close_allowed) else fail_run("Door permit given while car not stopped");
        car_hold = 1'b0;
        repeat (2) next_cycle();
        assert (door_close_allowed) else fail_run("Door permit missing while car stopped");
        door_close_btn = 1'b0;

        // Random presses, checked cycle by cycle
        for (int c = 0; c < 400; c++) begin
            rng_state = xorshift(rng_state);
            panel_buttons      = '0;
            floor_call_buttons = '0;
            if (rng_state[3:0] < 4'd3) begin
                panel_buttons[rng_state[31:8] % 24'd11] = 1'b1;
            end else if (rng_state[3:0] < 4'd5) begin
                floor_call_buttons[rng_state[31:8] % 24'd11] = 1'b1;
            end
            door_open_btn  = rng_state[4];
            door_close_btn = rng_state[5];
            next_cycle();
        end
        panel_buttons      = '0;
        floor_call_buttons = '0;
        wait_idle();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== elevator_request_ctrl.f ====
+incdir+src
src/elevator_pkg.sv
src/request_scanner.sv
src/request_stack.sv
src/dispatch_fsm.sv
src/elevator_request_ctrl.sv
tests/tb_elevator_request_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; the log decides pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_elevator_request_ctrl \
    -f elevator_request_ctrl.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
